/* source/mipsIsaPkg.sv */
//--------------------------------------------------------------------------
// MIPS subset: word and register types, opcode and funct encodings,
// decoded operation enumeration and the link register number
//--------------------------------------------------------------------------
package mipsIsaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // Operations after decode, carried down the pipeline
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_JAL,
        OP_JR
    } opT;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // Funct field of SPECIAL, instr[5:0]
    localparam logic [5:0] FUNCT_JR    = 6'h08;
    localparam logic [5:0] FUNCT_ADDU  = 6'h21;
    localparam logic [5:0] FUNCT_SUBU  = 6'h23;

    // jal writes its return address here
    localparam regAddrT REG_RA = 5'd31;

endpackage

/* source/mipsPipePkg.sv */
//--------------------------------------------------------------------------
// Pipeline stage-boundary payloads and their nop values
//--------------------------------------------------------------------------
package mipsPipePkg;
    import mipsIsaPkg::*;

    typedef struct packed {
        wordT instr;
        wordT pc;
    } ifIdT;

    typedef struct packed {
        opT          op;
        wordT        pc;
        wordT        rsData;
        wordT        rtData;
        logic [15:0] imm;
        regAddrT     rtAddr;
        regAddrT     rdAddr;
    } idExT;

    typedef struct packed {
        opT      op;
        wordT    pc;
        wordT    aluOut;
        wordT    storeData;
        regAddrT dest;
    } exMemT;

    typedef struct packed {
        opT      op;
        wordT    pc;
        wordT    data;
        regAddrT dest;
    } memWbT;

    // The all-zero instruction word decodes as a nop
    localparam ifIdT  IF_ID_NOP  = '{instr: '0, pc: '0};
    localparam idExT  ID_EX_NOP  = '{op: OP_NOP, default: '0};
    localparam exMemT EX_MEM_NOP = '{op: OP_NOP, default: '0};
    localparam memWbT MEM_WB_NOP = '{op: OP_NOP, default: '0};

endpackage

/* source/regWriteIf.sv */
//--------------------------------------------------------------------------
// Register-write bus from writeback to the register file
//--------------------------------------------------------------------------
interface regWriteIf import mipsIsaPkg::*; ();

    logic    en;
    // Never zero while en is high
    regAddrT addr;
    wordT    data;
    // PC of the retiring instruction, for the trace
    wordT    pc;

    modport driver (
        output en, addr, data, pc
    );

    modport receiver (
        input en, addr, data, pc
    );

endinterface

/* source/pipeReg.sv */
//--------------------------------------------------------------------------
// Generic pipeline stage register with a payload type parameter
//--------------------------------------------------------------------------
module pipeReg #(
    parameter type payloadT   = logic,
    parameter payloadT resetValue = '0
) (
    input  logic    clk,
    input  logic    arstN,
    input  payloadT d,
    output payloadT q
);

    // No stall or flush, so the stage advances every cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= resetValue;
        end else begin
            q <= d;
        end
    end

endmodule

/* source/fetchUnit.sv */
//--------------------------------------------------------------------------
// Program counter and next-PC selection
//--------------------------------------------------------------------------
module fetchUnit import mipsIsaPkg::*; #(
    parameter wordT resetPc = 32'h0000_3000
) (
    input  logic clk,
    input  logic arstN,
    input  logic redirect,
    input  wordT target,
    output wordT pc
);

    wordT nextPc;

    // Redirect comes from ID, so the word fetched meanwhile is the delay slot
    always_comb begin
        if (redirect) begin
            nextPc = target;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // A jr through a misaligned register value would break this
    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        pc[1:0] == 2'b00)
        else $error("fetch pc %h not word aligned", pc);

endmodule

/* source/regFile.sv */
//--------------------------------------------------------------------------
// General register file, 31 writable entries, write-through reads
//--------------------------------------------------------------------------
module regFile import mipsIsaPkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  regAddrT            rsAddr,
    input  regAddrT            rtAddr,
    regWriteIf.receiver        wr,
    output wordT               rsData,
    output wordT               rtData
);

    // $0 has no storage
    wordT regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Bypass the WB write so ID sees it in the same cycle
    function automatic wordT readPort(input regAddrT a);
        wordT v;
        if (a == '0) begin
            v = '0;
        end else if (wr.en && wr.addr == a) begin
            v = wr.data;
        end else begin
            v = regs[a];
        end
        return v;
    endfunction

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

endmodule

/* source/decodeUnit.sv */
//--------------------------------------------------------------------------
// ID stage: field split, operation decode, register read, beq compare
// and branch/jump target generation
//--------------------------------------------------------------------------
module decodeUnit import mipsIsaPkg::*; import mipsPipePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  ifIdT               ifId,
    regWriteIf.receiver        wr,
    output idExT               idEx,
    output logic               redirect,
    output wordT               target
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    regAddrT     rsAddr;
    regAddrT     rtAddr;
    regAddrT     rdAddr;
    logic [15:0] imm;
    logic [25:0] index;
    wordT        rsData;
    wordT        rtData;
    wordT        pcPlus4;
    wordT        branchTarget;
    wordT        jumpTarget;
    opT          op;
    logic        unsupported;

    assign opcode = ifId.instr[31:26];
    assign rsAddr = ifId.instr[25:21];
    assign rtAddr = ifId.instr[20:16];
    assign rdAddr = ifId.instr[15:11];
    assign funct  = ifId.instr[5:0];
    assign imm    = ifId.instr[15:0];
    assign index  = ifId.instr[25:0];

    regFile regs (
        .clk(clk), .arstN(arstN),
        .rsAddr(rsAddr), .rtAddr(rtAddr),
        .wr(wr),
        .rsData(rsData), .rtData(rtData)
    );

    always_comb begin
        op = OP_NOP;
        unsupported = 1'b0;
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FUNCT_ADDU: op = OP_ADDU;
                    FUNCT_SUBU: op = OP_SUBU;
                    FUNCT_JR:   op = OP_JR;
                    // Only the all-zero word is a legal nop here
                    default:    unsupported = (ifId.instr != '0);
                endcase
            end
            OPC_ORI: op = OP_ORI;
            OPC_LUI: op = OP_LUI;
            OPC_LW:  op = OP_LW;
            OPC_SW:  op = OP_SW;
            OPC_BEQ: op = OP_BEQ;
            OPC_JAL: op = OP_JAL;
            default: unsupported = 1'b1;
        endcase
    end

    assign pcPlus4      = ifId.pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], index, 2'b00};

    always_comb begin
        redirect = 1'b0;
        target   = branchTarget;
        case (op)
            OP_BEQ: redirect = (rsData == rtData);
            OP_JAL: begin
                redirect = 1'b1;
                target   = jumpTarget;
            end
            OP_JR: begin
                redirect = 1'b1;
                target   = rsData;
            end
            default: redirect = 1'b0;
        endcase
    end

    always_comb begin
        idEx.op     = op;
        idEx.pc     = ifId.pc;
        idEx.rsData = rsData;
        idEx.rtData = rtData;
        idEx.imm    = imm;
        idEx.rtAddr = rtAddr;
        idEx.rdAddr = rdAddr;
    end

    // Anything fetched outside the supported subset silently becomes a nop
    knownEncoding: assert property (@(posedge clk) disable iff (!arstN)
        !unsupported)
        else $error("unsupported instruction %h at pc %h", ifId.instr, ifId.pc);

endmodule

/* source/executeUnit.sv */
//--------------------------------------------------------------------------
// EX stage: ALU and destination register selection
//--------------------------------------------------------------------------
module executeUnit import mipsIsaPkg::*; import mipsPipePkg::*; (
    input  idExT  idEx,
    output exMemT exMem
);

    wordT immSigned;
    wordT immZero;

    assign immSigned = {{16{idEx.imm[15]}}, idEx.imm};
    assign immZero   = {16'h0000, idEx.imm};

    always_comb begin
        exMem.op        = idEx.op;
        exMem.pc        = idEx.pc;
        exMem.storeData = idEx.rtData;
        exMem.aluOut    = '0;
        // Zero destination means nothing is written back
        exMem.dest      = '0;
        case (idEx.op)
            OP_ADDU: begin
                exMem.aluOut = idEx.rsData + idEx.rtData;
                exMem.dest   = idEx.rdAddr;
            end
            OP_SUBU: begin
                exMem.aluOut = idEx.rsData - idEx.rtData;
                exMem.dest   = idEx.rdAddr;
            end
            OP_ORI: begin
                exMem.aluOut = idEx.rsData | immZero;
                exMem.dest   = idEx.rtAddr;
            end
            OP_LUI: begin
                exMem.aluOut = {idEx.imm, 16'h0000};
                exMem.dest   = idEx.rtAddr;
            end
            OP_LW: begin
                exMem.aluOut = idEx.rsData + immSigned;
                exMem.dest   = idEx.rtAddr;
            end
            OP_SW: begin
                exMem.aluOut = idEx.rsData + immSigned;
            end
            OP_JAL: begin
                // Return past the delay slot
                exMem.aluOut = idEx.pc + 32'd8;
                exMem.dest   = REG_RA;
            end
            default: begin
                exMem.aluOut = '0;
            end
        endcase
    end

endmodule

/* source/resultUnit.sv */
//--------------------------------------------------------------------------
// MEM stage: word-addressed data memory and writeback data select
//--------------------------------------------------------------------------
module resultUnit import mipsIsaPkg::*; import mipsPipePkg::*; #(
    parameter int dmemWords = 256
) (
    input  logic  clk,
    input  logic  arstN,
    input  exMemT exMem,
    output memWbT memWb
);

    localparam int idxBits = $clog2(dmemWords);

    wordT               dmem [dmemWords];
    logic [idxBits-1:0] idx;

    // Byte address to word index, upper bits wrap
    assign idx = exMem.aluOut[idxBits+1:2];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (exMem.op == OP_SW) begin
            dmem[idx] <= exMem.storeData;
        end
    end

    always_comb begin
        memWb.op   = exMem.op;
        memWb.pc   = exMem.pc;
        memWb.dest = exMem.dest;
        if (exMem.op == OP_LW) begin
            memWb.data = dmem[idx];
        end else begin
            memWb.data = exMem.aluOut;
        end
    end

    // Address comes from a register computed stages earlier
    memAligned: assert property (@(posedge clk) disable iff (!arstN)
        (exMem.op == OP_LW || exMem.op == OP_SW) |-> exMem.aluOut[1:0] == 2'b00)
        else $error("misaligned data access %h at pc %h", exMem.aluOut, exMem.pc);

endmodule

/* source/mips.sv */
//--------------------------------------------------------------------------
// Five-stage MIPS pipeline top: stages, stage registers, writeback
// enable and the retirement trace
//--------------------------------------------------------------------------
module mips import mipsIsaPkg::*; import mipsPipePkg::*; #(
    parameter wordT resetPc   = 32'h0000_3000,
    parameter int   dmemWords = 256
) (
    input  logic    clk,
    input  logic    arstN,
    output wordT    imemAddr,
    input  wordT    imemData,
    output logic    wbValid,
    output wordT    wbPc,
    output regAddrT wbAddr,
    output wordT    wbData
);

    wordT  pc;
    wordT  target;
    logic  redirect;
    ifIdT  ifIdD;
    ifIdT  ifIdQ;
    idExT  idExD;
    idExT  idExQ;
    exMemT exMemD;
    exMemT exMemQ;
    memWbT memWbD;
    memWbT memWbQ;
    logic  writesReg;

    regWriteIf rw ();

    // IF
    fetchUnit #(.resetPc(resetPc)) fetch (
        .clk(clk), .arstN(arstN),
        .redirect(redirect), .target(target),
        .pc(pc)
    );

    assign imemAddr    = pc;
    assign ifIdD.instr = imemData;
    assign ifIdD.pc    = pc;

    pipeReg #(.payloadT(ifIdT), .resetValue(IF_ID_NOP)) ifIdReg (
        .clk(clk), .arstN(arstN), .d(ifIdD), .q(ifIdQ)
    );

    // ID, register write from WB arrives over rw
    decodeUnit decode (
        .clk(clk), .arstN(arstN),
        .ifId(ifIdQ), .wr(rw),
        .idEx(idExD), .redirect(redirect), .target(target)
    );

    pipeReg #(.payloadT(idExT), .resetValue(ID_EX_NOP)) idExReg (
        .clk(clk), .arstN(arstN), .d(idExD), .q(idExQ)
    );

    // EX
    executeUnit execute (
        .idEx(idExQ), .exMem(exMemD)
    );

    pipeReg #(.payloadT(exMemT), .resetValue(EX_MEM_NOP)) exMemReg (
        .clk(clk), .arstN(arstN), .d(exMemD), .q(exMemQ)
    );

    // MEM
    resultUnit #(.dmemWords(dmemWords)) result (
        .clk(clk), .arstN(arstN),
        .exMem(exMemQ), .memWb(memWbD)
    );

    pipeReg #(.payloadT(memWbT), .resetValue(MEM_WB_NOP)) memWbReg (
        .clk(clk), .arstN(arstN), .d(memWbD), .q(memWbQ)
    );

    // WB
    always_comb begin
        case (memWbQ.op)
            OP_ADDU, OP_SUBU, OP_ORI, OP_LUI, OP_LW, OP_JAL: writesReg = 1'b1;
            default: writesReg = 1'b0;
        endcase
    end

    assign rw.en   = writesReg && (memWbQ.dest != '0);
    assign rw.addr = memWbQ.dest;
    assign rw.data = memWbQ.data;
    assign rw.pc   = memWbQ.pc;

    // Trace mirrors the register write
    assign wbValid = rw.en;
    assign wbPc    = rw.pc;
    assign wbAddr  = rw.addr;
    assign wbData  = rw.data;

endmodule

/* tb/mipsTb.sv */
//--------------------------------------------------------------------------
// Five-stage MIPS pipeline testbench with clock, reset, instruction ROM,
// trace monitor, LFSR, compare tasks, directed tests and timeout
//--------------------------------------------------------------------------
module mipsTb import mipsIsaPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam wordT RESET_PC  = 32'h0000_3000;
    localparam int   ROM_WORDS = 32;
    // Program lengths of all six tests added up
    localparam int   PROGRAM_WORDS  = 54;
    localparam int   NUM_TESTS      = 6;
    localparam int   TIMEOUT_CYCLES = 2 * PROGRAM_WORDS + 8 * NUM_TESTS;

    typedef struct packed {
        wordT    pc;
        regAddrT addr;
        wordT    data;
    } traceT;

    logic    clk;
    logic    arstN;
    wordT    imemAddr;
    wordT    imemData;
    logic    wbValid;
    wordT    wbPc;
    regAddrT wbAddr;
    wordT    wbData;

    wordT        rom [ROM_WORDS];
    wordT        prog [$];
    traceT       expected [$];
    traceT       observed [$];
    logic [15:0] lfsrState;
    int          errors;
    int          cycleCount;
    string       currentTest;

    mips #(.resetPc(RESET_PC), .dmemWords(256)) dut (
        .clk(clk), .arstN(arstN),
        .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbPc(wbPc), .wbAddr(wbAddr), .wbData(wbData)
    );

    always #4 clk = ~clk;

    // Instruction ROM returning nop outside the loaded program
    always_comb begin
        imemData = '0;
        if (imemAddr >= RESET_PC && imemAddr < RESET_PC + 4 * ROM_WORDS) begin
            imemData = rom[(imemAddr - RESET_PC) >> 2];
        end
    end

    // Retirement trace
    always @(posedge clk) begin
        if (arstN && wbValid) begin
            observed.push_back(traceT'{pc: wbPc, addr: wbAddr, data: wbData});
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles in %s", cycleCount, currentTest);
            $display("Errors: %0d", errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [15:0] lfsrBits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic wordT encR(regAddrT rs, regAddrT rt, regAddrT rd, logic [5:0] funct);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic wordT encI(logic [5:0] opc, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic wordT encJ(logic [5:0] opc, wordT target);
        return {opc, target[27:2]};
    endfunction

    function automatic wordT slotPc(int slot);
        return RESET_PC + 4 * slot;
    endfunction

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s in %s: got %h expected %h", name, currentTest, got, exp);
        end
    endtask

    task automatic checkRegAddr(string name, regAddrT got, regAddrT exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s in %s: got %h expected %h", name, currentTest, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s in %s: got %h expected %h", name, currentTest, got, exp);
        end
    endtask

    task automatic newTest(string name);
        currentTest = name;
        prog.delete();
        expected.delete();
    endtask

    task automatic expectWrite(wordT pc, regAddrT addr, wordT data);
        expected.push_back(traceT'{pc: pc, addr: addr, data: data});
    endtask

    // Reset for 3 cycles with the program loaded meanwhile
    task automatic startTest();
        @(negedge clk);
        arstN = 1'b0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = (i < prog.size()) ? prog[i] : '0;
        end
        observed.delete();
        repeat (3) begin
            @(negedge clk);
            checkFlag("wbValid", wbValid, 1'b0);
            checkWord("imemAddr", imemAddr, RESET_PC);
        end
        arstN = 1'b1;
    endtask

    // Wait for fetch to reach the program end and for the pipeline to drain
    task automatic runProgram();
        wordT endAddr;
        endAddr = slotPc(prog.size());
        while (imemAddr != endAddr) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
    endtask

    task automatic compareTrace();
        int n;
        n = (observed.size() < expected.size()) ? observed.size() : expected.size();
        if (observed.size() < expected.size()) begin
            errors++;
            $display("%s: trace entries missing, expected %0d but saw %0d",
                     currentTest, expected.size(), observed.size());
        end else if (observed.size() > expected.size()) begin
            errors++;
            $display("%s: extra trace entries, expected %0d but saw %0d",
                     currentTest, expected.size(), observed.size());
        end
        for (int i = 0; i < n; i++) begin
            checkWord($sformatf("wbPc[%0d]", i), observed[i].pc, expected[i].pc);
            checkRegAddr($sformatf("wbAddr[%0d]", i), observed[i].addr, expected[i].addr);
            checkWord($sformatf("wbData[%0d]", i), observed[i].data, expected[i].data);
        end
    endtask

    task automatic resetQuiet();
        newTest("resetQuiet");
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd1, 16'h1234));
        repeat (3) prog.push_back('0);
        expectWrite(RESET_PC, 5'd1, 32'h0000_1234);
        startTest();
        // Fetch steps sequentially from the reset address
        for (int i = 1; i <= 3; i++) begin
            @(negedge clk);
            checkFlag("wbValid", wbValid, 1'b0);
            checkWord("imemAddr", imemAddr, slotPc(i));
        end
        // First fetch retires four cycles after release
        @(negedge clk);
        checkFlag("wbValid", wbValid, 1'b1);
        checkWord("wbPc", wbPc, RESET_PC);
        runProgram();
        compareTrace();
    endtask

    task automatic aluOps();
        logic [15:0] imm1;
        logic [15:0] imm2;
        logic [15:0] imm3;
        wordT        r1;
        wordT        r2;
        wordT        r3;
        newTest("aluOps");
        imm1 = lfsrBits(16);
        imm2 = lfsrBits(16);
        imm3 = lfsrBits(16);
        r1 = {16'h0000, imm1};
        r2 = {imm2, 16'h0000};
        r3 = {16'h0000, imm3};
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd1, imm1));
        prog.push_back(encI(OPC_LUI, 5'd0, 5'd2, imm2));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd3, imm3));
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back(encR(5'd1, 5'd2, 5'd4, FUNCT_ADDU));
        prog.push_back(encR(5'd3, 5'd1, 5'd5, FUNCT_SUBU));
        expectWrite(slotPc(0), 5'd1, r1);
        expectWrite(slotPc(1), 5'd2, r2);
        expectWrite(slotPc(2), 5'd3, r3);
        expectWrite(slotPc(5), 5'd4, r1 + r2);
        expectWrite(slotPc(6), 5'd5, r3 - r1);
        startTest();
        runProgram();
        compareTrace();
    endtask

    task automatic loadStore();
        wordT a;
        wordT b;
        newTest("loadStore");
        a = {lfsrBits(16), lfsrBits(16)};
        b = {lfsrBits(16), lfsrBits(16)};
        prog.push_back(encI(OPC_LUI, 5'd0, 5'd1, a[31:16]));
        prog.push_back(encI(OPC_LUI, 5'd0, 5'd2, b[31:16]));
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back(encI(OPC_ORI, 5'd1, 5'd1, a[15:0]));
        prog.push_back(encI(OPC_ORI, 5'd2, 5'd2, b[15:0]));
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back(encI(OPC_SW, 5'd0, 5'd1, 16'h0010));
        prog.push_back(encI(OPC_SW, 5'd0, 5'd2, 16'h0024));
        prog.push_back(encI(OPC_LW, 5'd0, 5'd3, 16'h0010));
        prog.push_back(encI(OPC_LW, 5'd0, 5'd4, 16'h0024));
        expectWrite(slotPc(0), 5'd1, {a[31:16], 16'h0000});
        expectWrite(slotPc(1), 5'd2, {b[31:16], 16'h0000});
        expectWrite(slotPc(4), 5'd1, a);
        expectWrite(slotPc(5), 5'd2, b);
        expectWrite(slotPc(10), 5'd3, a);
        expectWrite(slotPc(11), 5'd4, b);
        startTest();
        runProgram();
        compareTrace();
    endtask

    task automatic branchDelaySlot();
        newTest("branchDelaySlot");
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd1, 16'h0005));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd2, 16'h0005));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd3, 16'h0007));
        prog.push_back('0);
        prog.push_back('0);
        // Taken, two words past the delay slot lands on slot 8
        prog.push_back(encI(OPC_BEQ, 5'd1, 5'd2, 16'd2));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd4, 16'h0011));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd6, 16'h0066));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd5, 16'h0022));
        // Not taken
        prog.push_back(encI(OPC_BEQ, 5'd1, 5'd3, 16'd2));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd7, 16'h0033));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd8, 16'h0044));
        expectWrite(slotPc(0), 5'd1, 32'h5);
        expectWrite(slotPc(1), 5'd2, 32'h5);
        expectWrite(slotPc(2), 5'd3, 32'h7);
        expectWrite(slotPc(6), 5'd4, 32'h11);
        expectWrite(slotPc(8), 5'd5, 32'h22);
        expectWrite(slotPc(10), 5'd7, 32'h33);
        expectWrite(slotPc(11), 5'd8, 32'h44);
        startTest();
        runProgram();
        compareTrace();
    endtask

    task automatic linkReturn();
        newTest("linkReturn");
        prog.push_back(encJ(OPC_JAL, slotPc(8)));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd1, 16'h0011));
        // Return point
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd2, 16'h0022));
        prog.push_back(encI(OPC_BEQ, 5'd0, 5'd0, 16'd8));
        repeat (4) prog.push_back('0);
        // Subroutine
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd3, 16'h0033));
        prog.push_back(encR(REG_RA, 5'd0, 5'd0, FUNCT_JR));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd4, 16'h0044));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd5, 16'h0055));
        expectWrite(slotPc(0), REG_RA, slotPc(0) + 32'd8);
        expectWrite(slotPc(1), 5'd1, 32'h11);
        expectWrite(slotPc(8), 5'd3, 32'h33);
        expectWrite(slotPc(10), 5'd4, 32'h44);
        expectWrite(slotPc(0) + 32'd8, 5'd2, 32'h22);
        startTest();
        runProgram();
        compareTrace();
    endtask

    task automatic zeroRegister();
        logic [15:0] v;
        newTest("zeroRegister");
        v = lfsrBits(16);
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd1, v));
        prog.push_back(encI(OPC_ORI, 5'd0, 5'd0, 16'h5a5a));
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back(encR(5'd1, 5'd1, 5'd0, FUNCT_ADDU));
        prog.push_back(encR(5'd0, 5'd1, 5'd2, FUNCT_ADDU));
        prog.push_back(encR(5'd1, 5'd0, 5'd3, FUNCT_ADDU));
        expectWrite(slotPc(0), 5'd1, {16'h0000, v});
        expectWrite(slotPc(5), 5'd2, {16'h0000, v});
        expectWrite(slotPc(6), 5'd3, {16'h0000, v});
        startTest();
        runProgram();
        compareTrace();
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        errors = 0;
        cycleCount = 0;
        lfsrState = 16'd98;
        currentTest = "init";
        resetQuiet();
        aluOps();
        loadStore();
        branchDelaySlot();
        linkReturn();
        zeroRegister();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
source/mipsIsaPkg.sv
source/mipsPipePkg.sv
source/regWriteIf.sv
source/pipeReg.sv
source/fetchUnit.sv
source/regFile.sv
source/decodeUnit.sv
source/executeUnit.sv
source/resultUnit.sv
source/mips.sv
tb/mipsTb.sv

/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - source/mipsIsaPkg.sv
  - source/mipsPipePkg.sv
  - source/regWriteIf.sv
  - source/pipeReg.sv
  - source/fetchUnit.sv
  - source/regFile.sv
  - source/decodeUnit.sv
  - source/executeUnit.sv
  - source/resultUnit.sv
  - source/mips.sv
  - target: test
    files:
      - tb/mipsTb.sv
